// File: verilog/cpu_pkg.sv
// Types and constants for the core, which runs binary mode only and starts at a fixed PC
package cpu_pkg;

    localparam int DATA_W = 8;
    localparam int ADDR_W = 16;

    typedef logic [DATA_W-1:0] data_t;
    typedef logic [ADDR_W-1:0] addr_t;

    localparam addr_t RESET_PC  = 16'h0200;    // First opcode fetched after reset
    localparam data_t ZERO_PAGE = 8'h00;       // High byte of zero-page accesses

    typedef enum logic [3:0] {
        FETCH,      // Operand or next opcode on the bus, ALU runs the instruction op
        DECODE,     // Opcode on di, previous result written back
        REG,        // Register-only instructions
        ZP0,        // Zero-page address on di
        ABS0,       // Absolute low byte
        ABS1,       // Absolute high byte, store happens here
        BRA0,       // Offset on di, added to PCL
        BRA1,       // Target low byte on the bus
        BRA2,       // Page fix-up
        JMP0,       // Target low byte
        JMP1        // Target high byte
    } state_e;

    typedef enum logic [2:0] {
        MODE_IMM,
        MODE_IMPL,      // Also catches unknown opcodes
        MODE_ZP,
        MODE_ABS,
        MODE_BRANCH,
        MODE_JUMP
    } mode_e;

    // Bits 3:2 pick the B operand, bits 1:0 the logic function
    typedef enum logic [3:0] {
        OP_OR     = 4'b1100,
        OP_AND    = 4'b1101,
        OP_EOR    = 4'b1110,
        OP_ADD    = 4'b0011,
        OP_SUB    = 4'b0111,
        OP_ROL    = 4'b1011,
        OP_PASS_A = 4'b1111
    } alu_op_e;

    typedef enum logic [1:0] {
        SEL_A,
        SEL_X,
        SEL_Y
    } reg_sel_e;

    typedef struct packed {
        alu_op_e    op;             // Main ALU op
        logic       shift_right;    // LSR/ROR
        reg_sel_e   src_reg;
        reg_sel_e   dst_reg;
        logic       load_reg;       // Result goes to dst_reg
        logic       load_only;      // LDA/LDX/LDY
        logic       store;          // STA/STX/STY
        logic       adc_sbc;
        logic       compare;        // CMP/CPX/CPY immediate
        logic       shift;
        logic       rotate;
        logic       inc;            // INX/INY
        logic       sec;
        logic       clc;
        logic       clv;
        logic [2:0] cond_code;      // Opcode bits 7:5
    } instr_t;

    typedef struct packed {
        state_e     state;
        alu_op_e    alu_op;
        logic       alu_right;
        reg_sel_e   regsel;
        logic       write_reg;
        logic       flag_upd;       // Flags take the previous ALU result
    } ctrl_t;

    typedef struct packed {
        logic n;
        logic v;
        logic z;
        logic c;
    } flags_t;

    typedef struct packed {
        data_t sum;
        logic  co;
        logic  z;
        logic  n;
        logic  v;
    } alu_res_t;

endpackage

// File: verilog/cpu_decode.sv
// Opcode decoder for the kept instruction set; any other opcode decodes as a register-path no-op
`timescale 1ns/1ps
module cpu_decode (
    input  logic              clk,
    input  logic              rdy,
    input  logic              decode_en,
    input  cpu_pkg::data_t    di,
    output cpu_pkg::mode_e    next_mode,
    output cpu_pkg::instr_t   instr,
    output logic              backwards
);

    cpu_pkg::instr_t dec;

    always_comb begin   // Path class straight from the bus
        case (di)
            8'h4c:                      next_mode = cpu_pkg::MODE_JUMP;
            8'h84, 8'h85, 8'h86,
            8'ha4, 8'ha5, 8'ha6:        next_mode = cpu_pkg::MODE_ZP;
            8'h8c, 8'h8d, 8'h8e:        next_mode = cpu_pkg::MODE_ABS;
            8'h09, 8'h29, 8'h49, 8'h69,
            8'ha0, 8'ha2, 8'ha9,
            8'hc0, 8'hc9, 8'he0, 8'he9: next_mode = cpu_pkg::MODE_IMM;
            default:                    next_mode = (di[4:0] == 5'b1_0000) ?
                                                    cpu_pkg::MODE_BRANCH :
                                                    cpu_pkg::MODE_IMPL;
        endcase
    end

    always_comb begin
        case (di)
            8'h09:                      dec.op = cpu_pkg::OP_OR;
            8'h29:                      dec.op = cpu_pkg::OP_AND;
            8'h49:                      dec.op = cpu_pkg::OP_EOR;
            8'he9, 8'hc9, 8'he0,
            8'hc0, 8'hca, 8'h88:        dec.op = cpu_pkg::OP_SUB;   // SBC, compares, DEX/DEY
            8'h0a, 8'h2a:               dec.op = cpu_pkg::OP_ROL;   // ASL A, ROL A
            8'h4a, 8'h6a:               dec.op = cpu_pkg::OP_PASS_A; // LSR A, ROR A
            default:                    dec.op = cpu_pkg::OP_ADD;
        endcase
        case (di)
            8'h86, 8'h8e, 8'he0,
            8'he8, 8'hca, 8'h8a:        dec.src_reg = cpu_pkg::SEL_X;
            8'h84, 8'h8c, 8'hc0,
            8'hc8, 8'h88, 8'h98:        dec.src_reg = cpu_pkg::SEL_Y;
            default:                    dec.src_reg = cpu_pkg::SEL_A;
        endcase
        case (di)
            8'ha2, 8'ha6, 8'he8,
            8'hca, 8'haa:               dec.dst_reg = cpu_pkg::SEL_X;
            8'ha0, 8'ha4, 8'hc8,
            8'h88, 8'ha8:               dec.dst_reg = cpu_pkg::SEL_Y;
            default:                    dec.dst_reg = cpu_pkg::SEL_A;
        endcase
        dec.shift_right = di inside {8'h4a, 8'h6a};
        dec.load_only   = di inside {8'ha9, 8'ha5, 8'ha2, 8'ha6, 8'ha0, 8'ha4};
        dec.store       = di inside {8'h85, 8'h86, 8'h84, 8'h8d, 8'h8e, 8'h8c};
        dec.adc_sbc     = di inside {8'h69, 8'he9};
        dec.compare     = di inside {8'hc9, 8'he0, 8'hc0};
        dec.shift       = di inside {8'h0a, 8'h2a, 8'h4a, 8'h6a};
        dec.rotate      = di inside {8'h2a, 8'h6a};
        dec.inc         = di inside {8'he8, 8'hc8};
        dec.load_reg    = dec.load_only | dec.adc_sbc | dec.shift |
                          (di inside {8'h09, 8'h29, 8'h49, 8'he8, 8'hc8, 8'hca,
                                      8'h88, 8'haa, 8'ha8, 8'h8a, 8'h98});
        dec.sec         = (di == 8'h38);
        dec.clc         = (di == 8'h18);
        dec.clv         = (di == 8'hb8);
        dec.cond_code   = di[7:5];      // Branch flag and polarity
    end

    always_ff @(posedge clk) begin
        if (rdy) begin
            backwards <= di[7];         // Offset sign, needed in BRA1
            if (decode_en)
                instr <= dec;
        end
    end

endmodule

// File: verilog/cpu_sequencer.sv
// Microcode sequencer for the kept addressing paths; the first write-back after reset is skipped
`timescale 1ns/1ps
module cpu_sequencer (
    input  logic              clk,
    input  logic              reset,
    input  logic              rdy,
    input  cpu_pkg::mode_e    next_mode,
    input  cpu_pkg::instr_t   instr,
    input  logic              cond_true,
    input  logic              alu_co,
    input  logic              backwards,
    output cpu_pkg::ctrl_t    ctrl,
    output logic              decode_en,
    output logic              we
);

    cpu_pkg::state_e state;
    logic            started;   // Set once a real opcode has been decoded

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= cpu_pkg::FETCH;
        end else if (rdy) begin
            case (state)
                cpu_pkg::DECODE: begin
                    case (next_mode)
                        cpu_pkg::MODE_IMM:    state <= cpu_pkg::FETCH;
                        cpu_pkg::MODE_ZP:     state <= cpu_pkg::ZP0;
                        cpu_pkg::MODE_ABS:    state <= cpu_pkg::ABS0;
                        cpu_pkg::MODE_BRANCH: state <= cpu_pkg::BRA0;
                        cpu_pkg::MODE_JUMP:   state <= cpu_pkg::JMP0;
                        default:              state <= cpu_pkg::REG;
                    endcase
                end
                cpu_pkg::ZP0:   state <= cpu_pkg::FETCH;
                cpu_pkg::ABS0:  state <= cpu_pkg::ABS1;
                cpu_pkg::ABS1:  state <= cpu_pkg::FETCH;
                cpu_pkg::BRA0:  state <= cond_true ? cpu_pkg::BRA1 : cpu_pkg::DECODE;
                cpu_pkg::BRA1:  state <= (alu_co ^ backwards) ? cpu_pkg::BRA2
                                                              : cpu_pkg::DECODE;
                cpu_pkg::JMP0:  state <= cpu_pkg::JMP1;
                default:        state <= cpu_pkg::DECODE;   // FETCH, REG, BRA2, JMP1
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset)
            started <= 1'b0;
        else if (rdy && state == cpu_pkg::DECODE)
            started <= 1'b1;
    end

    always_comb begin
        ctrl.state = state;
        case (state)
            cpu_pkg::FETCH,
            cpu_pkg::REG:   ctrl.alu_op = instr.op;
            cpu_pkg::BRA1:  ctrl.alu_op = backwards ? cpu_pkg::OP_SUB
                                                    : cpu_pkg::OP_ADD; // Page carry/borrow
            default:        ctrl.alu_op = cpu_pkg::OP_ADD;
        endcase
        ctrl.alu_right = (state == cpu_pkg::FETCH || state == cpu_pkg::REG) &&
                         instr.shift_right;
        ctrl.regsel    = (state == cpu_pkg::DECODE) ? instr.dst_reg : instr.src_reg;
        ctrl.write_reg = (state == cpu_pkg::DECODE) && started && instr.load_reg;
        ctrl.flag_upd  = (state == cpu_pkg::DECODE) && started;
    end

    assign decode_en = (state == cpu_pkg::DECODE);
    assign we        = (state == cpu_pkg::ZP0 || state == cpu_pkg::ABS1) && instr.store;

endmodule

// File: verilog/cpu_alu.sv
// Binary 8-bit ALU with 6502 operand rules; the result is valid one active cycle after its inputs
`timescale 1ns/1ps
module cpu_alu (
    input  logic               clk,
    input  logic               rdy,
    input  cpu_pkg::ctrl_t     ctrl,
    input  cpu_pkg::instr_t    instr,
    input  cpu_pkg::data_t     regfile,
    input  cpu_pkg::data_t     di,
    input  cpu_pkg::data_t     pcl,
    input  cpu_pkg::data_t     abh,
    input  logic               carry,
    output cpu_pkg::alu_res_t  res
);

    cpu_pkg::data_t ai;
    cpu_pkg::data_t bi;
    cpu_pkg::data_t bt;         // B after op select
    logic [3:0]     op;
    logic           ci;
    logic           adder_ci;
    logic [8:0]     lgc;        // Logic result, bit 8 is the shift-out
    logic [8:0]     sum9;

    assign op = ctrl.alu_op;

    always_comb begin
        case (ctrl.state)
            cpu_pkg::REG:   ai = regfile;
            cpu_pkg::BRA0:  ai = di;                            // Branch offset
            cpu_pkg::BRA1:  ai = abh;                           // Page of next opcode
            cpu_pkg::FETCH: ai = instr.load_only ? 8'h00 : regfile;
            default:        ai = 8'h00;
        endcase
        case (ctrl.state)
            cpu_pkg::REG,
            cpu_pkg::BRA1:  bi = 8'h00;
            cpu_pkg::BRA0:  bi = pcl;
            default:        bi = di;
        endcase
        case (ctrl.state)
            cpu_pkg::BRA1:  ci = res.co;                        // Carry from BRA0 add
            cpu_pkg::REG:   ci = instr.rotate ? carry : (instr.shift ? 1'b0 : instr.inc);
            cpu_pkg::FETCH: ci = instr.compare ? 1'b1 : (instr.load_only ? 1'b0 : carry);
            default:        ci = 1'b0;
        endcase
    end

    always_comb begin
        case (op[1:0])
            2'b00:   lgc = {1'b0, ai | bi};
            2'b01:   lgc = {1'b0, ai & bi};
            2'b10:   lgc = {1'b0, ai ^ bi};
            default: lgc = {1'b0, ai};
        endcase
        if (ctrl.alu_right)
            lgc = {ai[0], ci, ai[7:1]};                         // Carry in lands in bit 7
        case (op[3:2])
            2'b00:   bt = bi;
            2'b01:   bt = ~bi;
            2'b10:   bt = lgc[7:0];                             // A + A for ROL/ASL
            default: bt = 8'h00;
        endcase
    end

    assign adder_ci = (ctrl.alu_right || op[3:2] == 2'b11) ? 1'b0 : ci;
    assign sum9     = lgc + {1'b0, bt} + {8'h00, adder_ci};

    always_ff @(posedge clk) begin
        if (rdy) begin
            res.sum <= sum9[7:0];
            res.co  <= sum9[8];
            res.z   <= ~|sum9[7:0];
            res.n   <= sum9[7];
            res.v   <= ai[7] ^ bt[7] ^ sum9[8] ^ sum9[7];       // Carry into bit 7 vs out
        end
    end

endmodule

// File: verilog/cpu_regs_flags.sv
// A, X and Y registers with the N, V, Z and C flags; everything written in DECODE
`timescale 1ns/1ps
module cpu_regs_flags (
    input  logic               clk,
    input  logic               reset,
    input  logic               rdy,
    input  cpu_pkg::ctrl_t     ctrl,
    input  cpu_pkg::instr_t    instr,
    input  cpu_pkg::alu_res_t  res,
    input  logic [2:0]         cond_code,
    output cpu_pkg::data_t     regfile,
    output cpu_pkg::flags_t    flags,
    output logic               cond_true
);

    cpu_pkg::data_t axy [0:2];  // Indexed by reg_sel_e

    assign regfile = axy[ctrl.regsel];

    always_ff @(posedge clk) begin
        if (reset)
            axy <= '{default: 8'h00};
        else if (rdy && ctrl.write_reg)
            axy[ctrl.regsel] <= res.sum;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            flags <= '0;
        end else if (rdy && ctrl.flag_upd) begin
            if (instr.adc_sbc || instr.shift || instr.compare)
                flags.c <= res.co;
            else if (instr.sec)
                flags.c <= 1'b1;
            else if (instr.clc)
                flags.c <= 1'b0;
            if (instr.load_reg || instr.compare) begin
                flags.z <= res.z;
                flags.n <= res.n;
            end
            if (instr.adc_sbc)
                flags.v <= res.v;
            else if (instr.clv)
                flags.v <= 1'b0;
        end
    end

    always_comb begin
        case (cond_code)
            3'b000:  cond_true = ~flags.n;  // BPL
            3'b001:  cond_true = flags.n;   // BMI
            3'b010:  cond_true = ~flags.v;
            3'b011:  cond_true = flags.v;
            3'b100:  cond_true = ~flags.c;  // BCC
            3'b101:  cond_true = flags.c;   // BCS
            3'b110:  cond_true = ~flags.z;  // BNE
            default: cond_true = flags.z;   // BEQ
        endcase
    end

endmodule

// File: verilog/cpu_addr_gen.sv
// PC and address bus generation; the bus is combinational from the state and holds while rdy is low
`timescale 1ns/1ps
module cpu_addr_gen (
    input  logic               clk,
    input  logic               reset,
    input  logic               rdy,
    input  cpu_pkg::ctrl_t     ctrl,
    input  cpu_pkg::data_t     di,
    input  cpu_pkg::data_t     regfile,
    input  cpu_pkg::alu_res_t  res,
    input  logic               backwards,
    output cpu_pkg::addr_t     ab,
    output cpu_pkg::data_t     dout,
    output cpu_pkg::data_t     pcl,
    output cpu_pkg::data_t     abh
);

    cpu_pkg::addr_t pc;
    cpu_pkg::addr_t pc_temp;
    logic           pc_inc;
    cpu_pkg::data_t abl;

    always_comb begin
        case (ctrl.state)
            cpu_pkg::JMP1:  pc_temp = {di, res.sum};
            cpu_pkg::BRA1:  pc_temp = {abh, res.sum};       // Same-page target
            cpu_pkg::BRA2:  pc_temp = {res.sum, pcl};       // Fixed-up page
            default:        pc_temp = pc;
        endcase
        case (ctrl.state)
            cpu_pkg::DECODE,
            cpu_pkg::FETCH,
            cpu_pkg::ABS0,
            cpu_pkg::BRA0,
            cpu_pkg::BRA2,
            cpu_pkg::JMP1:  pc_inc = 1'b1;
            cpu_pkg::BRA1:  pc_inc = ~(res.co ^ backwards); // No page crossing
            default:        pc_inc = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset)
            pc <= cpu_pkg::RESET_PC;
        else if (rdy)
            pc <= pc_temp + {{(cpu_pkg::ADDR_W-1){1'b0}}, pc_inc};
    end

    always_comb begin
        case (ctrl.state)
            cpu_pkg::ABS1,
            cpu_pkg::JMP1:  ab = {di, res.sum};
            cpu_pkg::BRA1:  ab = {abh, res.sum};
            cpu_pkg::BRA2:  ab = {res.sum, abl};
            cpu_pkg::ZP0:   ab = {cpu_pkg::ZERO_PAGE, di};
            cpu_pkg::REG:   ab = {abh, abl};                // Re-read next opcode
            default:        ab = pc;
        endcase
    end

    always_ff @(posedge clk) begin  // Last bus address
        if (rdy) begin
            abh <= ab[15:8];
            abl <= ab[7:0];
        end
    end

    assign pcl  = pc[7:0];
    assign dout = regfile;          // Stores only come from A, X or Y

endmodule

// File: verilog/cpu_core.sv
// Core top level with separate read and write buses; memory must return data one active cycle later
`timescale 1ns/1ps
module cpu_core (
    input  logic            clk,
    input  logic            reset,
    output cpu_pkg::addr_t  ab,
    input  cpu_pkg::data_t  di,
    output cpu_pkg::data_t  dout,
    output logic            we,
    input  logic            rdy
);

    cpu_pkg::ctrl_t    ctrl;
    cpu_pkg::instr_t   instr;
    cpu_pkg::mode_e    next_mode;
    cpu_pkg::alu_res_t res;
    cpu_pkg::flags_t   flags;
    cpu_pkg::data_t    regfile;
    cpu_pkg::data_t    pcl;
    cpu_pkg::data_t    abh;
    logic              decode_en;
    logic              backwards;
    logic              cond_true;

    cpu_decode decode_i (
        .clk       (clk),
        .rdy       (rdy),
        .decode_en (decode_en),
        .di        (di),
        .next_mode (next_mode),
        .instr     (instr),
        .backwards (backwards)
    );

    cpu_sequencer sequencer_i (
        .clk       (clk),
        .reset     (reset),
        .rdy       (rdy),
        .next_mode (next_mode),
        .instr     (instr),
        .cond_true (cond_true),
        .alu_co    (res.co),
        .backwards (backwards),
        .ctrl      (ctrl),
        .decode_en (decode_en),
        .we        (we)
    );

    cpu_alu alu_i (
        .clk     (clk),
        .rdy     (rdy),
        .ctrl    (ctrl),
        .instr   (instr),
        .regfile (regfile),
        .di      (di),
        .pcl     (pcl),
        .abh     (abh),
        .carry   (flags.c),
        .res     (res)
    );

    cpu_regs_flags regs_flags_i (
        .clk       (clk),
        .reset     (reset),
        .rdy       (rdy),
        .ctrl      (ctrl),
        .instr     (instr),
        .res       (res),
        .cond_code (instr.cond_code),
        .regfile   (regfile),
        .flags     (flags),
        .cond_true (cond_true)
    );

    cpu_addr_gen addr_gen_i (
        .clk       (clk),
        .reset     (reset),
        .rdy       (rdy),
        .ctrl      (ctrl),
        .di        (di),
        .regfile   (regfile),
        .res       (res),
        .backwards (backwards),
        .ab        (ab),
        .dout      (dout),
        .pcl       (pcl),
        .abh       (abh)
    );

endmodule

// File: bench/cpu_properties.sv
// Bus rules on the core ports; dout may be unknown right after reset until the first decode
`timescale 1ns/1ps
module cpu_properties (
    input logic           clk,
    input logic           reset,
    input logic           rdy,
    input logic           we,
    input cpu_pkg::addr_t ab,
    input cpu_pkg::data_t dout
);

    assert property (@(posedge clk) $fell(reset) |-> !we)     // First cycle out of reset
        else $error("we is high in the first cycle after reset");

    assert property (@(posedge clk) disable iff (reset)
                     !rdy |=> ($stable(ab) && $stable(dout) && $stable(we)))
        else $error("bus outputs changed while rdy was low");

    assert property (@(posedge clk) we |-> !$isunknown({ab, dout}))
        else $error("unknown bits on ab or dout during a write");

endmodule

bind cpu_core cpu_properties props_i (
    .clk   (clk),
    .reset (reset),
    .rdy   (rdy),
    .we    (we),
    .ab    (ab),
    .dout  (dout)
);

// File: bench/cpu_tb.sv
// Random acyclic program checked write by write against a model; binary mode and forward branches only
`timescale 1ns/1ps
module cpu_tb;

    logic            clk = 1'b0;
    logic            reset;
    logic            rdy;
    cpu_pkg::data_t  di;
    cpu_pkg::data_t  dout;
    cpu_pkg::addr_t  ab;
    logic            we;

    logic [7:0]      mem [0:65535];     // Memory seen by the DUT
    logic [7:0]      mm  [0:65535];     // Model copy
    logic [23:0]     exp_writes [$];    // {addr, data} in program order
    integer          seed;
    integer          wr_count;
    integer          cycles;
    integer          limit;
    int              wp;                // Program write pointer
    logic            bus_valid;         // Bus state at the coming edge
    logic            bus_we;
    cpu_pkg::addr_t  bus_ab;
    cpu_pkg::data_t  bus_dout;
    logic [7:0]      reg_a, reg_x, reg_y;
    logic            fc, fz, fn, fv;

    cpu_core dut_i (
        .clk   (clk),
        .reset (reset),
        .ab    (ab),
        .di    (di),
        .dout  (dout),
        .we    (we),
        .rdy   (rdy)
    );

    always #5 clk = ~clk;

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("RESULT: FAIL");
        $fatal(1, "run stopped at first error");
    endtask

    function automatic int rnd(input int n);
        int r;
        r = $random(seed);
        return (r & 32'h7fff_ffff) % n;
    endfunction

    function automatic logic [7:0] rbyte();
        int v;
        v = rnd(256);
        return v[7:0];
    endfunction

    function automatic logic [7:0] pick(input logic [63:0] ops, input int n);
        int i;
        i = rnd(n);
        return ops[i*8 +: 8];           // Low bytes hold the choices
    endfunction

    task automatic emit(input logic [7:0] b);
        mem[wp[15:0]] = b;
        wp++;
    endtask

    task automatic emit_simple(input int kind);
        case (kind)
            0:       begin emit(pick(64'ha9a2a0, 3)); emit(rbyte()); end   // LDx #
            1:       begin emit(pick(64'ha5a6a4, 3)); emit(8'h10 + 8'(rnd(16))); end
            2, 10:   begin emit(pick(64'h858684, 3)); emit(8'h10 + 8'(rnd(16))); end
            3, 11:   begin emit(pick(64'h8d8e8c, 3)); emit(rbyte()); emit(8'h80); end
            4, 5:    begin emit(pick(64'h69e9_2909_49c9_e0c0, 8)); emit(rbyte()); end
            6:       emit(pick(64'h0a4a_2a6a, 4));                     // Accumulator shifts
            7, 8:    emit(pick(64'he8c8_ca88_aaa8_8a98, 8));
            default: emit(pick(64'h1838_b8ea, 4));                     // Flags and NOP
        endcase
    endtask

    task automatic gen_program();
        int k;
        int kind;
        int g;
        int pend;
        int patch_at;
        int off;
        logic [15:0] t;
        wp   = cpu_pkg::RESET_PC;
        pend = 0;
        patch_at = 0;
        for (k = 0; k < 200; k++) begin
            kind = rnd(12);
            if (kind == 11 && pend == 0) begin
                emit(pick(64'h1030_90b0_d0f0, 6));  // Branch, offset patched later
                patch_at = wp;
                emit(8'h00);
                if (rnd(4) == 0) begin              // Long NOP gap for page crossings
                    g = 1 + rnd(100);
                    repeat (g) emit(8'hea);
                    mem[patch_at[15:0]] = g[7:0];
                end else begin
                    pend = 1 + rnd(3);
                end
            end else if (kind == 10 && pend == 0) begin
                g = rnd(4);
                t = 16'(wp + 3 + g);                // Forward JMP over NOPs
                emit(8'h4c);
                emit(t[7:0]);
                emit(t[15:8]);
                repeat (g) emit(8'hea);
            end else begin
                emit_simple(kind);
                if (pend > 0) begin
                    pend--;
                    if (pend == 0) begin
                        off = wp - patch_at - 1;
                        mem[patch_at[15:0]] = off[7:0];
                    end
                end
            end
        end
        if (pend > 0) begin
            off = wp - patch_at - 1;
            mem[patch_at[15:0]] = off[7:0];
        end
        emit(8'h8d);                                // Final A, X, Y dump
        emit(8'h00);
        emit(8'h81);
        emit(8'h8e);
        emit(8'h01);
        emit(8'h81);
        emit(8'h8c);
        emit(8'h02);
        emit(8'h81);
        t = wp[15:0];
        emit(8'h4c);                                // Park
        emit(t[7:0]);
        emit(t[15:8]);
    endtask

    task automatic set_zn(input logic [7:0] r);
        fz = (r == 8'h00);
        fn = r[7];
    endtask

    task automatic model_store(input logic [15:0] a, input logic [7:0] d);
        mm[a] = d;
        exp_writes.push_back({a, d});
    endtask

    task automatic model_add(input logic [7:0] d);
        logic [8:0] s;
        s  = {1'b0, reg_a} + {1'b0, d} + {8'h00, fc};
        fv = (reg_a[7] == d[7]) && (s[7] != reg_a[7]);  // Same-sign inputs, sign flip
        fc = s[8];
        reg_a = s[7:0];
        set_zn(reg_a);
    endtask

    task automatic model_compare(input logic [7:0] r, input logic [7:0] d);
        fc = (r >= d);
        set_zn(r - d);
    endtask

    task automatic run_model();
        int          i;
        int          steps;
        logic [15:0] pc;
        logic [15:0] t;
        logic [7:0]  op;
        logic [7:0]  d;
        logic        take;
        logic        done;
        for (i = 0; i < 65536; i++)
            mm[i] = mem[i];
        {reg_a, reg_x, reg_y} = '0;
        {fc, fz, fn, fv} = '0;
        pc = cpu_pkg::RESET_PC;
        done = 1'b0;
        steps = 0;
        while (!done) begin
            op = mm[pc];
            d  = mm[pc + 16'd1];
            t  = {mm[pc + 16'd2], d};
            steps++;
            if (steps > 10000)
                fail_run("Model ran away without reaching the final jump");
            case (op)
                8'ha9: begin reg_a = d; set_zn(d); pc += 2; end
                8'ha2: begin reg_x = d; set_zn(d); pc += 2; end
                8'ha0: begin reg_y = d; set_zn(d); pc += 2; end
                8'ha5: begin reg_a = mm[{8'h00, d}]; set_zn(reg_a); pc += 2; end
                8'ha6: begin reg_x = mm[{8'h00, d}]; set_zn(reg_x); pc += 2; end
                8'ha4: begin reg_y = mm[{8'h00, d}]; set_zn(reg_y); pc += 2; end
                8'h85: begin model_store({8'h00, d}, reg_a); pc += 2; end
                8'h86: begin model_store({8'h00, d}, reg_x); pc += 2; end
                8'h84: begin model_store({8'h00, d}, reg_y); pc += 2; end
                8'h8d: begin model_store(t, reg_a); pc += 3; end
                8'h8e: begin model_store(t, reg_x); pc += 3; end
                8'h8c: begin model_store(t, reg_y); pc += 3; end
                8'h69: begin model_add(d); pc += 2; end
                8'he9: begin model_add(~d); pc += 2; end    // Borrow is inverted carry
                8'h29: begin reg_a = reg_a & d; set_zn(reg_a); pc += 2; end
                8'h09: begin reg_a = reg_a | d; set_zn(reg_a); pc += 2; end
                8'h49: begin reg_a = reg_a ^ d; set_zn(reg_a); pc += 2; end
                8'hc9: begin model_compare(reg_a, d); pc += 2; end
                8'he0: begin model_compare(reg_x, d); pc += 2; end
                8'hc0: begin model_compare(reg_y, d); pc += 2; end
                8'h0a: begin {fc, reg_a} = {reg_a, 1'b0}; set_zn(reg_a); pc += 1; end
                8'h4a: begin {reg_a, fc} = {1'b0, reg_a}; set_zn(reg_a); pc += 1; end
                8'h2a: begin {fc, reg_a} = {reg_a, fc}; set_zn(reg_a); pc += 1; end
                8'h6a: begin {reg_a, fc} = {fc, reg_a}; set_zn(reg_a); pc += 1; end
                8'he8: begin reg_x = reg_x + 8'd1; set_zn(reg_x); pc += 1; end
                8'hc8: begin reg_y = reg_y + 8'd1; set_zn(reg_y); pc += 1; end
                8'hca: begin reg_x = reg_x - 8'd1; set_zn(reg_x); pc += 1; end
                8'h88: begin reg_y = reg_y - 8'd1; set_zn(reg_y); pc += 1; end
                8'haa: begin reg_x = reg_a; set_zn(reg_x); pc += 1; end
                8'ha8: begin reg_y = reg_a; set_zn(reg_y); pc += 1; end
                8'h8a: begin reg_a = reg_x; set_zn(reg_a); pc += 1; end
                8'h98: begin reg_a = reg_y; set_zn(reg_a); pc += 1; end
                8'h18: begin fc = 1'b0; pc += 1; end
                8'h38: begin fc = 1'b1; pc += 1; end
                8'hb8: begin fv = 1'b0; pc += 1; end
                8'hea: pc += 1;
                8'h10, 8'h30, 8'h90, 8'hb0, 8'hd0, 8'hf0: begin
                    case (op)
                        8'h10:   take = ~fn;
                        8'h30:   take = fn;
                        8'h90:   take = ~fc;
                        8'hb0:   take = fc;
                        8'hd0:   take = ~fz;
                        default: take = fz;
                    endcase
                    pc = pc + 16'd2 + (take ? {{8{d[7]}}, d} : 16'h0000);
                end
                8'h4c: begin
                    if (t == pc)
                        done = 1'b1;            // Jump to self ends the program
                    else
                        pc = t;
                end
                default: fail_run($sformatf("Model found unexpected opcode %h at %h", op, pc));
            endcase
        end
    endtask

    task automatic check_write(input cpu_pkg::addr_t a, input cpu_pkg::data_t d);
        assert (wr_count < exp_writes.size())
            else fail_run($sformatf("Unexpected extra write of %h to address %h", d, a));
        assert ({a, d} == exp_writes[wr_count])
            else fail_run($sformatf("MISMATCH test=write_%0d expected=%h actual=%h",
                                    wr_count, exp_writes[wr_count], {a, d}));
        wr_count++;
    endtask

    always @(negedge clk) begin
        if (bus_valid) begin                    // Previous edge was active
            if (bus_we) begin
                check_write(bus_ab, bus_dout);
                mem[bus_ab] = bus_dout;
            end
            di = mem[bus_ab];                   // Synchronous read data
        end
        rdy = ($random(seed) & 3) != 0;         // About 75 percent high
        #1;
        bus_valid = rdy && !reset;
        bus_we    = we;
        bus_ab    = ab;
        bus_dout  = dout;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > limit)
            fail_run($sformatf("Timeout after %0d cycles with %0d of %0d writes seen",
                               cycles, wr_count, exp_writes.size()));
    end

    initial begin
        seed      = 32'h45ae_c9b4;
        reset     = 1'b1;
        rdy       = 1'b1;
        di        = 8'h00;
        wr_count  = 0;
        cycles    = 0;
        bus_valid = 1'b0;
        limit     = 1_000_000;
        for (int i = 0; i < 65536; i++)
            mem[i] = (i[7:0] * 8'd29) ^ i[15:8] ^ 8'h5a;
        gen_program();
        run_model();
        limit = (wp - cpu_pkg::RESET_PC) * 16 + 2000;  // Two active cycles per byte at most
        repeat (8) @(negedge clk);
        reset = 1'b0;
        wait (wr_count == exp_writes.size());
        repeat (50) @(negedge clk);             // Parked core must stay silent
        $display("RESULT: PASS");
        $finish;
    end

endmodule

// File: mini6502.f
verilog/cpu_pkg.sv
verilog/cpu_decode.sv
verilog/cpu_sequencer.sv
verilog/cpu_alu.sv
verilog/cpu_regs_flags.sv
verilog/cpu_addr_gen.sv
verilog/cpu_core.sv
bench/cpu_properties.sv
bench/cpu_tb.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = cpu_tb
FILELIST  = mini6502.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "RESULT: PASS" $(LOG); then echo "Simulation ended without a pass"; exit 1; fi

lint:
	$(VERILATOR) --lint-only --timing -Wall --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
